// ==== asic_daq.f ====
hw/bus_pkg.sv
hw/readout_pkg.sv
hw/bank_decoder.sv
hw/settings_bank.sv
hw/command_pulser.sv
hw/serial_deframer.sv
hw/word_fifo.sv
hw/status_readback.sv
hw/asic_daq_top.sv
bench/daq_props.sv
bench/daq_checker.sv
bench/asic_daq_tb.sv

// ==== Makefile ====
# Verilator build and run of the register-bank controller testbench

VERILATOR ?= verilator
TOP       ?= asic_daq_tb
FILELIST  ?= asic_daq.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/asic_daq_tb.sv ====
module asic_daq_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import bus_pkg::*;
	import readout_pkg::*;

	localparam int FIFO_DEPTH_LOG2 = 4;
	// cycle budget per test
	// a frame is 18 cycles plus up to 15 idle
	localparam int BUDGET = 8 + 60 + 120 + 120 + 12 * 34 + 60 + 20 * 19 + 60 + 80;
	localparam int MAX_CYCLES = BUDGET + 500; // margin

	logic            sysclk;
	logic            reset;
	logic            serial_in;
	bus_request_t    bus_req;
	data_word_t      read_data;
	logic            read_valid;
	command_pulses_t commands;
	occurred_t       status_leds;
	logic            mode_select;
	logic [15:0]     lfsr = 16'd87; // seed

	asic_daq_top #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) UUT (.sysclk(sysclk), .reset(reset),
		.bus_req(bus_req), .serial_in(serial_in), .read_data(read_data),
		.read_valid(read_valid), .commands(commands), .status_leds(status_leds),
		.mode_select(mode_select));

	daq_checker chk (.sysclk(sysclk), .reset(reset), .bus_req(bus_req),
		.serial_in(serial_in), .read_data(read_data), .read_valid(read_valid),
		.commands(commands), .status_leds(status_leds), .mode_select(mode_select));

	initial begin
		sysclk = 1'b0;
		forever #5 sysclk = ~sysclk;
	end

	// fibonacci lfsr with taps 16 14 13 11
	// stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// ------------------------------------------------
	// host side
	task automatic bus_op(input bus_op_t op, input bank_t bank, input reg_addr_t addr,
		input data_word_t wdata);
		@(posedge sysclk);
		#1;
		bus_req.op    = op;
		bus_req.bank  = bank;
		bus_req.addr  = addr;
		bus_req.wdata = wdata;
	endtask

	task automatic bus_idle();
		@(posedge sysclk);
		#1 bus_req.op = OP_NONE;
	endtask

	// wait for every read to come back
	task automatic drain();
		int n;
		n = 0;
		bus_idle();
		while (chk.pending() != 0 && n < 20) begin
			@(posedge sysclk);
			#1 n++;
		end
		if (chk.pending() != 0) chk.fault("reads still pending after 20 cycles");
	endtask

	task automatic send_frame(input logic [15:0] w);
		@(posedge sysclk);
		#1 serial_in = 1'b1; // start bit
		for (int i = 15; i >= 0; i--) begin
			@(posedge sysclk);
			#1 serial_in = w[i];
		end
		@(posedge sysclk);
		#1 serial_in = 1'b0;
	endtask

	task automatic read_fifo(input int count);
		repeat (count) bus_op(OP_READ, BANK_FIFO, 4'd0, '0);
		bus_op(OP_READ, BANK_STATUS, 4'd2, '0);
		bus_op(OP_READ, BANK_STATUS, 4'd3, '0);
		bus_op(OP_READ, BANK_STATUS, 4'd4, '0);
		drain();
	endtask

	// ------------------------------------------------
	// test sequence
	initial begin
		reset = 1'b1;
		serial_in = 1'b0;
		bus_req = '0;
		repeat (8) @(posedge sysclk);
		#1 reset = 1'b0;

		for (int a = 0; a < 16; a++) bus_op(OP_READ, BANK_STATUS, reg_addr_t'(a), '0);
		for (int a = 0; a < 16; a++) bus_op(OP_READ, BANK_SETTINGS, reg_addr_t'(a), '0);
		drain();
		chk.end_test("reset values");

		repeat (2) begin
			repeat (24) begin
				bus_op(OP_WRITE, BANK_SETTINGS, reg_addr_t'(rand_bits(4)),
					rand_bits(32));
			end
			for (int a = 0; a < 16; a++) bus_op(OP_READ, BANK_SETTINGS, reg_addr_t'(a), '0);
		end
		drain();
		chk.end_test("settings bank");

		repeat (30) begin
			bus_op(OP_WRITE, BANK_PULSE, reg_addr_t'(rand_bits(2)), rand_bits(32));
			bus_idle(); // keeps pulses apart
		end
		bus_op(OP_WRITE, BANK_PULSE, 4'd9, '1); // unused address
		bus_op(OP_READ, BANK_STATUS, 4'd0, '0);
		bus_op(OP_READ, BANK_STATUS, 4'd1, '0);
		drain();
		chk.end_test("command pulses");

		repeat (12) begin
			send_frame(16'(rand_bits(16)));
			repeat (rand_bits(4)) @(posedge sysclk);
		end
		repeat (3) @(posedge sysclk);
		read_fifo(12);
		chk.end_test("serial frames");

		repeat (20) send_frame(16'(rand_bits(16))); // overflows the fifo
		repeat (3) @(posedge sysclk);
		read_fifo(20);
		chk.end_test("fifo overflow");

		for (int b = 3; b < 8; b++) begin
			if (b != 5) begin
				bus_op(OP_WRITE, bank_t'(b), reg_addr_t'(rand_bits(4)), rand_bits(32));
				bus_op(OP_READ, bank_t'(b), reg_addr_t'(rand_bits(4)), '0);
			end
		end
		for (int a = 0; a < 5; a++) bus_op(OP_READ, BANK_STATUS, reg_addr_t'(a), '0);
		for (int a = 0; a < 16; a++) bus_op(OP_READ, BANK_SETTINGS, reg_addr_t'(a), '0);
		drain();
		chk.end_test("unused banks");

		chk.report();
		if (chk.error_count == 0 && UUT.props.assert_failures == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(MAX_CYCLES * 10);
		$display("watchdog expired, tests did not finish in %0d cycles", MAX_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== bench/daq_checker.sv ====
module daq_checker (
	input logic                         sysclk,
	input logic                         reset,
	input bus_pkg::bus_request_t        bus_req,
	input logic                         serial_in,
	input bus_pkg::data_word_t          read_data,
	input logic                         read_valid,
	input readout_pkg::command_pulses_t commands,
	input readout_pkg::occurred_t       status_leds,
	input logic                         mode_select
);
	timeunit 1ns;
	timeprecision 100ps;
	import bus_pkg::*;
	import readout_pkg::*;

	data_word_t      settings [16]; // model of bank 0
	occurred_t       occ, occ_p1, occ_p2;
	command_pulses_t cmd_p1, cmd_p2; // expected pulses two cycles on
	logic            ms_p1, ms_p2;
	logic [7:0]      trig_cnt;
	data_word_t      received, fifo_reads;
	logic [15:0]     words [$];     // fifo contents
	data_word_t      exp_data [$];  // reads in flight
	int              exp_due [$];
	int              bits_left;     // 0 = line idle
	logic [15:0]     shreg;
	int              cycle;
	int              error_count = 0;
	int              test_errors = 0;
	int              tests_run = 0;
	int              tests_failed = 0;

	task automatic mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		$display("error t=%0t %s: got %h expected %h", $time, name, got, expected);
		error_count++;
		test_errors++;
	endtask

	task automatic fault(input string msg);
		$display("t=%0t %s", $time, msg);
		error_count++;
		test_errors++;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors != 0) tests_failed++;
		$display("test %0d %s: %s, %0d errors", tests_run, name,
			(test_errors == 0) ? "ok" : "failed", test_errors);
		test_errors = 0;
	endtask

	task automatic report();
		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
	endtask

	function automatic int pending();
		return exp_due.size();
	endfunction

	// ------------------------------------------------
	// model stepped on every edge
	always @(posedge sysclk) begin
		if (reset) begin
			foreach (settings[i]) settings[i] = '0;
			occ = '0;
			occ_p1 = '0;
			occ_p2 = '0;
			cmd_p1 = '0;
			cmd_p2 = '0;
			ms_p1 = 1'b0;
			ms_p2 = 1'b0;
			trig_cnt = '0;
			received = '0;
			fifo_reads = '0;
			words.delete();
			exp_data.delete();
			exp_due.delete();
			bits_left = 0;
			cycle = 0;
		end else begin
			cycle++;
			// read return
			if (exp_due.size() > 0 && exp_due[0] == cycle) begin
				if (!read_valid) begin
					fault("read_valid did not arrive 3 cycles after a read");
				end else if (read_data !== exp_data[0]) begin
					mismatch("read_data", read_data, exp_data[0]);
				end
				void'(exp_due.pop_front());
				void'(exp_data.pop_front());
			end else if (read_valid) begin
				fault("read_valid without a pending read");
			end
			if (commands !== cmd_p2) begin
				mismatch("commands", 32'(commands), 32'(cmd_p2));
			end
			if (status_leds !== occ_p2) begin
				mismatch("status_leds", 32'(status_leds), 32'(occ_p2));
			end
			if (mode_select !== ms_p2) begin
				mismatch("mode_select", 32'(mode_select), 32'(ms_p2));
			end
			cmd_p2 = cmd_p1;
			cmd_p1 = '0;

			// serial frame rule
			if (bits_left == 0) begin
				if (serial_in) bits_left = 16; // start bit
			end else begin
				shreg = {shreg[14:0], serial_in};
				bits_left--;
				if (bits_left == 0) begin
					received++;
					if (words.size() < 16) words.push_back(shreg); // full fifo drops it
				end
			end

			// host request
			if (bus_req.op == OP_WRITE) begin
				if (bus_req.bank == BANK_SETTINGS) settings[bus_req.addr] = bus_req.wdata;
				if (bus_req.bank == BANK_PULSE && bus_req.addr < 4) begin
					case (bus_req.addr)
						4'd0: begin
							cmd_p1.dreset = 1'b1;
							occ.dreset = 1'b1;
						end
						4'd1: begin
							cmd_p1.legacy_serial = 1'b1;
							occ.legacy_serial = 1'b1;
						end
						4'd2: begin
							cmd_p1.i2c = 1'b1;
							occ.i2c = 1'b1;
						end
						default: begin
							cmd_p1.trigger = 1'b1;
							occ.trigger = 1'b1;
							trig_cnt++;
						end
					endcase
				end
			end else if (bus_req.op == OP_READ) begin
				case (bus_req.bank)
					BANK_SETTINGS: exp_data.push_back(settings[bus_req.addr]);
					BANK_STATUS: begin
						case (bus_req.addr)
							4'd0: exp_data.push_back({28'd0, occ});
							4'd1: exp_data.push_back({24'd0, trig_cnt});
							4'd2: exp_data.push_back(received);
							4'd3: exp_data.push_back(fifo_reads);
							4'd4: exp_data.push_back({31'd0, words.size() == 0});
							default: exp_data.push_back('0);
						endcase
					end
					BANK_FIFO: begin
						fifo_reads++; // empty reads count too
						if (words.size() > 0) exp_data.push_back({16'd0, words.pop_front()});
						else exp_data.push_back('0);
					end
					default: exp_data.push_back('0);
				endcase
				exp_due.push_back(cycle + 3);
			end
			occ_p2 = occ_p1;
			occ_p1 = occ;
			ms_p2 = ms_p1;
			ms_p1 = settings[0][0];
		end
	end

endmodule

// ==== bench/daq_props.sv ====
module daq_props (
	input logic                         sysclk,
	input logic                         reset,
	input bus_pkg::bus_request_t        bus_req,
	input logic                         read_valid,
	input readout_pkg::command_pulses_t commands
);
	timeunit 1ns;
	timeprecision 100ps;
	import bus_pkg::*;

	int assert_failures = 0; // failed assertions so far

	// ------------------------------------------------
	// read return three cycles after the request
	a_read_latency : assert property (@(posedge sysclk) disable iff (reset)
		(bus_req.op == OP_READ) |-> ##3 read_valid)
		else begin
			$error("read_valid missing 3 cycles after a read request");
			assert_failures++;
		end

	a_no_stray_valid : assert property (@(posedge sysclk) disable iff (reset)
		read_valid |-> $past(bus_req.op == OP_READ, 3))
		else begin
			$error("read_valid without a read request 3 cycles earlier");
			assert_failures++;
		end

	// command pulses
	a_one_command : assert property (@(posedge sysclk) disable iff (reset)
		$onehot0(commands))
		else begin
			$error("more than one command pulse at once");
			assert_failures++;
		end

	a_pulse_width : assert property (@(posedge sysclk) disable iff (reset)
		(commands != '0) |=> (commands == '0))
		else begin
			$error("command pulse longer than one cycle");
			assert_failures++;
		end

endmodule

bind asic_daq_top daq_props props (.sysclk(sysclk), .reset(reset), .bus_req(bus_req),
	.read_valid(read_valid), .commands(commands));

// ==== hw/asic_daq_top.sv ====
module asic_daq_top #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input  logic                          sysclk,
	input  logic                          reset,
	input  bus_pkg::bus_request_t         bus_req,
	input  logic                          serial_in,
	output bus_pkg::data_word_t           read_data,
	output logic                          read_valid,
	output readout_pkg::command_pulses_t  commands,
	output readout_pkg::occurred_t        status_leds,
	output logic                          mode_select
);
	import bus_pkg::*;
	import readout_pkg::*;

	bank_strobes_t strobes;
	data_word_t    settings_data;
	sample_word_t  asic_word;   // deframer out
	logic          word_valid;
	sample_word_t  fifo_word;   // fifo out, registered
	logic          fifo_empty;
	logic [7:0]    trigger_count;

	// ------------------------------------------------
	// register bus, stages 1 and 2
	bank_decoder decoder (.sysclk(sysclk), .reset(reset), .bus_req(bus_req), .strobes(strobes));

	settings_bank settings (.sysclk(sysclk), .reset(reset), .strobes(strobes),
		.rdata(settings_data), .mode_select(mode_select));

	command_pulser pulser (.sysclk(sysclk), .reset(reset), .strobes(strobes),
		.commands(commands), .occurred(status_leds), .trigger_count(trigger_count));

	// ------------------------------------------------
	// asic data path
	serial_deframer deframer (.sysclk(sysclk), .reset(reset), .serial_in(serial_in),
		.word(asic_word), .word_valid(word_valid));

	word_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) fifo (.sysclk(sysclk), .reset(reset),
		.wr_data(asic_word), .wr_en(word_valid),
		.rd_en(strobes.rd[BANK_FIFO]), .rd_data(fifo_word), // bank 5 read pops
		.empty(fifo_empty), .full());

	// stage 3, read data return
	status_readback #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) readback (.sysclk(sysclk),
		.reset(reset), .strobes(strobes), .word_valid(word_valid),
		.settings_data(settings_data), .fifo_word(fifo_word), .occurred(status_leds),
		.trigger_count(trigger_count), .fifo_empty(fifo_empty),
		.read_data(read_data), .read_valid(read_valid));

endmodule

// ==== hw/status_readback.sv ====
module status_readback #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input  logic                      sysclk,
	input  logic                      reset,
	input  bus_pkg::bank_strobes_t    strobes,
	input  logic                      word_valid,
	input  bus_pkg::data_word_t       settings_data,
	input  readout_pkg::sample_word_t fifo_word,
	input  readout_pkg::occurred_t    occurred,
	input  logic [7:0]                trigger_count,
	input  logic                      fifo_empty,
	output bus_pkg::data_word_t       read_data,
	output logic                      read_valid
);
	import bus_pkg::*;

	// fifo pointers above 16 bits would not fit the counters' use
	if (FIFO_DEPTH_LOG2 < 1 || FIFO_DEPTH_LOG2 > 16) begin : g_depth_check
		$error("status_readback: FIFO_DEPTH_LOG2 out of range");
	end

	logic [NUM_BANKS-1:0] rd_d;   // read strobes, stage 2 copy
	reg_addr_t            addr_d;
	data_word_t           words_received;
	data_word_t           fifo_reads;
	data_word_t           status_word;
	data_word_t           selected;

	// ------------------------------------------------
	// event counters
	always_ff @(posedge sysclk) begin
		if (reset) begin
			words_received <= '0;
			fifo_reads     <= '0;
			rd_d           <= '0;
		end else begin
			if (word_valid) words_received <= words_received + 32'd1; // dropped ones too
			if (strobes.rd[BANK_FIFO]) fifo_reads <= fifo_reads + 32'd1;
			rd_d <= strobes.rd; // line up with stage 2 outputs
		end
	end

	always_ff @(posedge sysclk) begin
		addr_d <= strobes.addr;
	end

	// status bank word select
	always_comb begin
		case (addr_d)
			4'd0:    status_word = {28'd0, occurred};
			4'd1:    status_word = {24'd0, trigger_count};
			4'd2:    status_word = words_received;
			4'd3:    status_word = fifo_reads;
			4'd4:    status_word = {31'd0, fifo_empty};
			default: status_word = '0;
		endcase
	end

	// one-hot, so at most one term is live
	assign selected = (rd_d[BANK_SETTINGS] ? settings_data : '0) |
		(rd_d[BANK_STATUS] ? status_word : '0) |
		(rd_d[BANK_FIFO] ? {16'd0, fifo_word} : '0);

	// ------------------------------------------------
	// stage 3, return
	always_ff @(posedge sysclk) begin
		if (reset) begin
			read_valid <= 1'b0;
		end else begin
			read_valid <= |rd_d; // unused banks still answer, with 0
		end
	end

	always_ff @(posedge sysclk) begin
		read_data <= selected;
	end

endmodule

// ==== hw/word_fifo.sv ====
module word_fifo #(
	parameter int FIFO_DEPTH_LOG2 = 4
) (
	input  logic                      sysclk,
	input  logic                      reset,
	input  readout_pkg::sample_word_t wr_data,
	input  logic                      wr_en,
	input  logic                      rd_en,
	output readout_pkg::sample_word_t rd_data,
	output logic                      empty,
	output logic                      full
);
	import readout_pkg::*;

	localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

	sample_word_t mem [DEPTH];

	// extra msb tells full from empty
	logic [FIFO_DEPTH_LOG2:0] wr_ptr;
	logic [FIFO_DEPTH_LOG2:0] rd_ptr;
	logic                     push;
	logic                     pop;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[FIFO_DEPTH_LOG2] != rd_ptr[FIFO_DEPTH_LOG2]) &&
		(wr_ptr[FIFO_DEPTH_LOG2-1:0] == rd_ptr[FIFO_DEPTH_LOG2-1:0]);
	assign push  = wr_en && !full;  // asic can't wait, word is lost
	assign pop   = rd_en && !empty;

	always_ff @(posedge sysclk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (pop)  rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge sysclk) begin
		if (push) mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= wr_data;
		if (rd_en) rd_data <= pop ? mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]] : '0; // empty reads give 0
	end

endmodule

// ==== hw/serial_deframer.sv ====
module serial_deframer (
	input  logic                      sysclk,
	input  logic                      reset,
	input  logic                      serial_in,
	output readout_pkg::sample_word_t word,
	output logic                      word_valid
);
	import readout_pkg::*;

	localparam int CNT_W = $clog2(FRAME_BITS);

	logic             busy;    // inside a frame
	logic [CNT_W-1:0] bit_cnt; // data bits taken so far

	// ------------------------------------------------
	// frame control
	// idle low, a 1 while idle is the start bit
	always_ff @(posedge sysclk) begin
		if (reset) begin
			busy       <= 1'b0;
			bit_cnt    <= '0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= 1'b0;
			if (!busy) begin
				if (serial_in) begin
					busy    <= 1'b1;
					bit_cnt <= '0;
				end
			end else begin
				bit_cnt <= bit_cnt + 1'b1;
				if (bit_cnt == CNT_W'(FRAME_BITS - 1)) begin
					busy       <= 1'b0; // idle again right away
					word_valid <= 1'b1; // lines up with the last shift
				end
			end
		end
	end

	// msb first, so shift in from the bottom
	always_ff @(posedge sysclk) begin
		if (busy) begin
			word <= {word[FRAME_BITS-2:0], serial_in};
		end
	end

endmodule

// ==== hw/command_pulser.sv ====
module command_pulser (
	input  logic                       sysclk,
	input  logic                       reset,
	input  bus_pkg::bank_strobes_t     strobes,
	output readout_pkg::command_pulses_t commands,
	output readout_pkg::occurred_t     occurred,
	output logic [7:0]                 trigger_count
);
	import bus_pkg::*;

	// ------------------------------------------------
	// pulse bank, a write to addr 0..3 fires one command
	always_ff @(posedge sysclk) begin
		if (reset) begin
			commands      <= '0;
			occurred      <= '0;
			trigger_count <= '0;
		end else begin
			commands <= '0; // default low, so pulses are one cycle
			if (strobes.wr[BANK_PULSE]) begin
				case (strobes.addr)
					4'd0: begin
						commands.dreset <= 1'b1;
						occurred.dreset <= 1'b1;
					end
					4'd1: begin
						commands.legacy_serial <= 1'b1;
						occurred.legacy_serial <= 1'b1;
					end
					4'd2: begin
						commands.i2c <= 1'b1;
						occurred.i2c <= 1'b1;
					end
					4'd3: begin
						commands.trigger <= 1'b1;
						occurred.trigger <= 1'b1;
						trigger_count    <= trigger_count + 8'd1; // wraps at 256
					end
					default: ; // 4..15 unused
				endcase
			end
		end
	end

endmodule

// ==== hw/settings_bank.sv ====
module settings_bank (
	input  logic                   sysclk,
	input  logic                   reset,
	input  bus_pkg::bank_strobes_t strobes,
	output bus_pkg::data_word_t    rdata,
	output logic                   mode_select
);
	import bus_pkg::*;

	data_word_t settings [WORDS_PER_BANK]; // general settings words

	// ------------------------------------------------
	// write port, stage 2
	always_ff @(posedge sysclk) begin
		if (reset) begin
			for (int i = 0; i < WORDS_PER_BANK; i++) begin
				settings[i] <= '0;
			end
		end else if (strobes.wr[BANK_SETTINGS]) begin
			settings[strobes.addr] <= strobes.wdata;
		end
	end

	// ------------------------------------------------
	// read port, registered every cycle
	// status_readback decides whether anyone wanted it
	always_ff @(posedge sysclk) begin
		rdata <= settings[strobes.addr];
	end

	// word 0 bit 0 straight out as a level
	assign mode_select = settings[0][0]; // 0 = i2c, 1 = legacy serial

endmodule

// ==== hw/bank_decoder.sv ====
module bank_decoder (
	input  logic                  sysclk,
	input  logic                  reset,
	input  bus_pkg::bus_request_t bus_req,
	output bus_pkg::bank_strobes_t strobes
);
	import bus_pkg::*;

	// stage 1, request register plus one-hot decode
	always_ff @(posedge sysclk) begin
		if (reset) begin
			strobes.wr <= '0;
			strobes.rd <= '0;
		end else begin
			strobes.wr <= '0; // strobes last a single cycle
			strobes.rd <= '0;
			if (bus_req.op == OP_WRITE) begin
				strobes.wr[bus_req.bank] <= 1'b1;
			end
			if (bus_req.op == OP_READ) begin
				strobes.rd[bus_req.bank] <= 1'b1;
			end
		end
	end

	// address and data just ride along
	always_ff @(posedge sysclk) begin
		strobes.addr  <= bus_req.addr;
		strobes.wdata <= bus_req.wdata;
	end

endmodule

// ==== hw/readout_pkg.sv ====
package readout_pkg;

	// one deserialized asic word
	typedef logic [15:0] sample_word_t;

	localparam int FRAME_BITS = 16; // data bits after the start bit

	// same bit order in both structs, dreset at the top
	typedef struct packed {
		logic dreset;
		logic legacy_serial;
		logic i2c;
		logic trigger;
	} command_pulses_t;

	typedef struct packed {
		logic dreset;
		logic legacy_serial;
		logic i2c;
		logic trigger;
	} occurred_t; // sticky, cleared only by reset

endpackage

// ==== hw/bus_pkg.sv ====
package bus_pkg;

	// ------------------------------------------------
	// register bus as seen by the host
	localparam int NUM_BANKS      = 8;
	localparam int WORDS_PER_BANK = 16;

	typedef logic [2:0]  bank_t;     // bank number
	typedef logic [3:0]  reg_addr_t; // word within a bank
	typedef logic [31:0] data_word_t;

	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_READ  = 2'd1,
		OP_WRITE = 2'd2
	} bus_op_t;

	typedef struct packed {
		bus_op_t    op;
		bank_t      bank;
		reg_addr_t  addr;
		data_word_t wdata;
	} bus_request_t; // 41 bits

	typedef struct packed {
		logic [NUM_BANKS-1:0] wr; // one-hot, bit n = bank n
		logic [NUM_BANKS-1:0] rd;
		reg_addr_t            addr;
		data_word_t           wdata;
	} bank_strobes_t; // 52 bits

	// ------------------------------------------------
	// bank map
	localparam bank_t BANK_SETTINGS = 3'd0;
	localparam bank_t BANK_STATUS   = 3'd1;
	localparam bank_t BANK_PULSE    = 3'd2;
	localparam bank_t BANK_FIFO     = 3'd5; // asic data, pops on read

endpackage
